/* id_defs.svh */
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath and address width
`define XLEN 32

// instruction word width
`define INST_W 32

// register file index width
`define REG_ADDR_W 5

// link address is the next sequential instruction
`define RAS_LINK_OFFSET 4

// fixed system words, matched on all 32 bits
`define ECALL_ENC 32'h0000_0073
`define EBREAK_ENC 32'h0010_0073
`define MRET_ENC 32'h3020_0073

`endif

/* id_pkg.sv */
`include "id_defs.svh"
`default_nettype none

package id_pkg;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_auipc  = 7'b0010111,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // binary coded, none is zero
  typedef enum logic [4:0] {
    alu_none, alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_e;

  typedef enum logic [3:0] {
    exc_none, exc_auipc, exc_lui, exc_jal, exc_jalr, exc_load,
    exc_store, exc_branch, exc_opimm, exc_op, exc_system
  } exc_op_e;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
    mem_sb, mem_sh, mem_sw
  } mem_op_e;

  typedef enum logic [2:0] {
    fmt_none, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } imm_fmt_e;

  typedef struct packed {
    logic mret;
    logic ebreak;
    logic ecall;
    logic illegal;
  } trap_t;

  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic [`INST_W-1:0] inst;
  } if_id_t;

  // memory stage result for the bypass
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_data;
  } mem_bypass_t;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rs1_idx;
    logic [`REG_ADDR_W-1:0] rs2_idx;
    logic [`REG_ADDR_W-1:0] rd_idx;
    alu_op_e                alu_op;
    exc_op_e                exc_op;
    mem_op_e                mem_op;
    imm_fmt_e               imm_fmt;
    trap_t                  trap;
    logic                   is_call;
  } decode_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rs1_idx;
    logic [`REG_ADDR_W-1:0] rs2_idx;
    logic [`REG_ADDR_W-1:0] rd_idx;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    exc_op_e                exc_op;
    mem_op_e                mem_op;
    trap_t                  trap;
  } id_ex_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
`include "id_defs.svh"
`default_nettype none

module inst_decoder import id_pkg::*; (
  input  logic [`INST_W-1:0] inst_i,
  output decode_t            dec_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  logic       alt;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;
  alu_op_e    alu_op;
  exc_op_e    exc_op;
  mem_op_e    mem_op;
  imm_fmt_e   imm_fmt;

  // op and op_imm share the funct3 map, alt picks sub or sra
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_sel);
    case (f3)
      3'b000:  arith_op = alt_sel ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt_sel ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    legal   = 1'b1;
    alt     = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    use_rd  = 1'b0;
    alu_op  = alu_none;
    exc_op  = exc_none;
    mem_op  = mem_none;
    imm_fmt = fmt_none;
    case (opcode)
      opc_lui, opc_auipc: begin
        exc_op  = (opcode == opc_lui) ? exc_lui : exc_auipc;
        alu_op  = alu_add;
        imm_fmt = fmt_u;
        use_rd  = 1'b1;
      end
      opc_jal: begin
        exc_op  = exc_jal;
        alu_op  = alu_add;
        imm_fmt = fmt_j;
        use_rd  = 1'b1;
      end
      opc_jalr: begin
        legal   = (funct3 == 3'b000);
        exc_op  = exc_jalr;
        alu_op  = alu_add;
        imm_fmt = fmt_i;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      opc_branch: begin
        exc_op  = exc_branch;
        imm_fmt = fmt_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  alu_op = alu_beq;
          3'b001:  alu_op = alu_bne;
          3'b100:  alu_op = alu_blt;
          3'b101:  alu_op = alu_bge;
          3'b110:  alu_op = alu_bltu;
          3'b111:  alu_op = alu_bgeu;
          default: legal = 1'b0;
        endcase
      end
      opc_load: begin
        exc_op  = exc_load;
        alu_op  = alu_add;
        imm_fmt = fmt_i;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
        case (funct3)
          3'b000:  mem_op = mem_lb;
          3'b001:  mem_op = mem_lh;
          3'b010:  mem_op = mem_lw;
          3'b100:  mem_op = mem_lbu;
          3'b101:  mem_op = mem_lhu;
          default: legal = 1'b0;
        endcase
      end
      opc_store: begin
        exc_op  = exc_store;
        alu_op  = alu_add;
        imm_fmt = fmt_s;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  mem_op = mem_sb;
          3'b001:  mem_op = mem_sh;
          3'b010:  mem_op = mem_sw;
          default: legal = 1'b0;
        endcase
      end
      opc_op_imm: begin
        // shift amounts sit in the imm field, funct7 still checked
        alt = (funct3 == 3'b101) && funct7[5];
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
        exc_op  = exc_opimm;
        alu_op  = arith_op(funct3, alt);
        imm_fmt = fmt_i;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      opc_op: begin
        // rv32m funct7 lands here as illegal
        alt   = funct7[5];
        legal = (funct7 == 7'b0000000) ||
                ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
        exc_op  = id_pkg::exc_op;
        alu_op  = arith_op(funct3, alt);
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      opc_system: begin
        // only the three fixed words, csr accesses are not supported
        legal   = (inst_i == `ECALL_ENC) || (inst_i == `EBREAK_ENC) || (inst_i == `MRET_ENC);
        exc_op  = exc_system;
        imm_fmt = fmt_i;
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      use_rd  = 1'b0;
      alu_op  = alu_none;
      exc_op  = exc_none;
      mem_op  = mem_none;
      imm_fmt = fmt_none;
    end
  end

  assign dec_o.rs1_idx = use_rs1 ? inst_i[19:15] : '0;
  assign dec_o.rs2_idx = use_rs2 ? inst_i[24:20] : '0;
  assign dec_o.rd_idx  = use_rd ? inst_i[11:7] : '0;
  assign dec_o.alu_op  = alu_op;
  assign dec_o.exc_op  = exc_op;
  assign dec_o.mem_op  = mem_op;
  assign dec_o.imm_fmt = imm_fmt;

  assign dec_o.trap.mret    = (inst_i == `MRET_ENC);
  assign dec_o.trap.ebreak  = (inst_i == `EBREAK_ENC);
  assign dec_o.trap.ecall   = (inst_i == `ECALL_ENC);
  assign dec_o.trap.illegal = !legal;

  // call means a link register other than x0
  assign dec_o.is_call = ((exc_op == exc_jal) || (exc_op == exc_jalr)) &&
                         (inst_i[11:7] != '0);

endmodule

`default_nettype wire

/* imm_gen.sv */
`include "id_defs.svh"
`default_nettype none

module imm_gen import id_pkg::*; (
  input  logic [`INST_W-1:0] inst_i,
  input  imm_fmt_e           fmt_i,
  output logic [`XLEN-1:0]   imm_o
);

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  // bit 31 is the sign in every layout
  assign imm_i = {{21{inst_i[31]}}, inst_i[30:20]};
  assign imm_s = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    case (fmt_i)
      id_pkg::fmt_i: imm_o = imm_i;
      fmt_s:   imm_o = imm_s;
      fmt_b:   imm_o = imm_b;
      fmt_u:   imm_o = imm_u;
      fmt_j:   imm_o = imm_j;
      default: imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* operand_forward.sv */
`include "id_defs.svh"
`default_nettype none

module operand_forward import id_pkg::*; (
  input  decode_t                dec_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic [`REG_ADDR_W-1:0] ex_rd_idx_i,
  input  exc_op_e                ex_exc_op_i,
  input  logic [`XLEN-1:0]       ex_rd_data_i,
  input  mem_bypass_t            mem_bypass_i,
  output logic [`XLEN-1:0]       rs1_fwd_o,
  output logic [`XLEN-1:0]       rs2_fwd_o,
  output logic                   load_use_o
);

  logic rs1_hits_ex;
  logic rs2_hits_ex;

  // execute beats memory beats register file, x0 never bypassed
  function automatic logic [`XLEN-1:0] pick(
    input logic [`REG_ADDR_W-1:0] idx,
    input logic [`XLEN-1:0]       rf_data,
    input logic [`REG_ADDR_W-1:0] ex_idx,
    input logic [`XLEN-1:0]       ex_data,
    input mem_bypass_t            mem
  );
    pick = rf_data;
    if (idx != '0) begin
      if (idx == ex_idx) begin
        pick = ex_data;
      end else if (idx == mem.rd_addr) begin
        pick = mem.rd_data;
      end
    end
  endfunction

  assign rs1_fwd_o = pick(dec_i.rs1_idx, rs1_data_i, ex_rd_idx_i, ex_rd_data_i, mem_bypass_i);
  assign rs2_fwd_o = pick(dec_i.rs2_idx, rs2_data_i, ex_rd_idx_i, ex_rd_data_i, mem_bypass_i);

  assign rs1_hits_ex = (dec_i.rs1_idx != '0) && (dec_i.rs1_idx == ex_rd_idx_i);
  assign rs2_hits_ex = (dec_i.rs2_idx != '0) && (dec_i.rs2_idx == ex_rd_idx_i);

  // load data is not ready until the memory stage
  assign load_use_o = (ex_exc_op_i == exc_load) && (rs1_hits_ex || rs2_hits_ex);

endmodule

`default_nettype wire

/* id_ex_reg.sv */
`include "id_defs.svh"
`default_nettype none

module id_ex_reg import id_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  input  logic             stall_i,
  input  logic [`XLEN-1:0] pc_i,
  input  decode_t          dec_i,
  input  logic [`XLEN-1:0] imm_i,
  input  logic [`XLEN-1:0] rs1_i,
  input  logic [`XLEN-1:0] rs2_i,
  output id_ex_t           id_ex_o
);

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i || stall_i) begin
      // bubble, the none op encodings are all zero
      id_ex_o <= '0;
    end else begin
      id_ex_o.pc       <= pc_i;
      id_ex_o.rs1_idx  <= dec_i.rs1_idx;
      id_ex_o.rs2_idx  <= dec_i.rs2_idx;
      id_ex_o.rd_idx   <= dec_i.rd_idx;
      id_ex_o.rs1_data <= rs1_i;
      id_ex_o.rs2_data <= rs2_i;
      id_ex_o.imm      <= imm_i;
      id_ex_o.alu_op   <= dec_i.alu_op;
      id_ex_o.exc_op   <= dec_i.exc_op;
      id_ex_o.mem_op   <= dec_i.mem_op;
      id_ex_o.trap     <= dec_i.trap;
    end
  end

endmodule

`default_nettype wire

/* id_stage.sv */
`include "id_defs.svh"
`default_nettype none

module id_stage import id_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  if_id_t                 if_id_i,
  input  logic                   flush_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic [`XLEN-1:0]       ex_rd_data_i,
  input  mem_bypass_t            mem_bypass_i,
  output logic [`REG_ADDR_W-1:0] rs1_idx_o,
  output logic [`REG_ADDR_W-1:0] rs2_idx_o,
  output id_ex_t                 id_ex_o,
  output logic                   stall_o,
  output logic                   ras_push_valid_o,
  output logic [`XLEN-1:0]       ras_push_data_o
);

  decode_t          dec;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1_fwd;
  logic [`XLEN-1:0] rs2_fwd;
  logic             load_use;

  inst_decoder u_decoder (
    .inst_i (if_id_i.inst),
    .dec_o  (dec)
  );

  imm_gen u_imm_gen (
    .inst_i (if_id_i.inst),
    .fmt_i  (dec.imm_fmt),
    .imm_o  (imm)
  );

  // execute stage address comes from our own register
  operand_forward u_forward (
    .dec_i        (dec),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .ex_rd_idx_i  (id_ex_o.rd_idx),
    .ex_exc_op_i  (id_ex_o.exc_op),
    .ex_rd_data_i (ex_rd_data_i),
    .mem_bypass_i (mem_bypass_i),
    .rs1_fwd_o    (rs1_fwd),
    .rs2_fwd_o    (rs2_fwd),
    .load_use_o   (load_use)
  );

  id_ex_reg u_id_ex (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .stall_i (load_use),
    .pc_i    (if_id_i.pc),
    .dec_i   (dec),
    .imm_i   (imm),
    .rs1_i   (rs1_fwd),
    .rs2_i   (rs2_fwd),
    .id_ex_o (id_ex_o)
  );

  // register file read addresses
  assign rs1_idx_o = dec.rs1_idx;
  assign rs2_idx_o = dec.rs2_idx;

  assign stall_o = load_use;

  // return address push for calls, dropped on flush
  assign ras_push_valid_o = dec.is_call && !flush_i;
  assign ras_push_data_o  = if_id_i.pc + `XLEN'(`RAS_LINK_OFFSET);

endmodule

`default_nettype wire

/* id_stage_props.sv */
`default_nettype none

module id_stage_props import id_pkg::*; (
  input logic   clk_i,
  input logic   reset_i,
  input logic   flush_i,
  input logic   stall_o,
  input logic   ras_push_valid_o,
  input id_ex_t id_ex_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fails = 0;

  // a killed or held slot leaves a bubble behind
  bubble_after_kill: assert property (
    @(posedge clk_i) (reset_i || flush_i || stall_o) |=> (id_ex_o == '0)
  ) else begin
    fails++;
    $error("id_ex_o not a bubble after reset, flush or stall");
  end

  stall_only_on_load: assert property (
    @(posedge clk_i) disable iff (reset_i) stall_o |-> (id_ex_o.exc_op == exc_load)
  ) else begin
    fails++;
    $error("stall_o high without a load in execute");
  end

  no_push_on_flush: assert property (
    @(posedge clk_i) disable iff (reset_i) flush_i |-> !ras_push_valid_o
  ) else begin
    fails++;
    $error("return address push during flush");
  end

endmodule

bind id_stage id_stage_props u_props (.*);

`default_nettype wire

/* tb_id_stage.sv */
`include "id_defs.svh"
`default_nettype none

module tb_id_stage import id_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RANDOM    = 400;
  localparam int CYCLE_LIMIT = 2 * (N_RANDOM + 32) + 16 + 100;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic clk = 1'b0;
  logic reset_i;
  if_id_t if_id;
  logic flush_i;
  logic [31:0] rs1_data_i, rs2_data_i, ex_rd_data_i;
  mem_bypass_t mem_bypass_i;
  logic [4:0] rs1_idx_o, rs2_idx_o;
  id_ex_t id_ex_o;
  logic stall_o, ras_push_valid_o;
  logic [31:0] ras_push_data_o;

  integer seed = 89;
  logic [31:0] rf [32];
  logic [31:0] prog_inst [$];
  bit prog_flush [$];
  logic [31:0] next_pc = 32'h0000_1000;
  logic [6:0] undef_ops [4] = '{7'h0b, 7'h2b, 7'h5b, 7'h7b};
  bit done = 1'b0;

  // expected state of the model
  id_ex_t exp_ex = '0;
  logic exp_stall = 1'b0;
  logic exp_push = 1'b0;
  logic [31:0] exp_push_data = '0;
  logic [4:0] exp_rs1_idx = '0;
  logic [4:0] exp_rs2_idx = '0;
  decode_t d, nd;
  logic hold, n_flush;
  if_id_t n_if;
  mem_bypass_t new_mem;

  id_stage dut (
    .clk_i            (clk),
    .reset_i          (reset_i),
    .if_id_i          (if_id),
    .flush_i          (flush_i),
    .rs1_data_i       (rs1_data_i),
    .rs2_data_i       (rs2_data_i),
    .ex_rd_data_i     (ex_rd_data_i),
    .mem_bypass_i     (mem_bypass_i),
    .rs1_idx_o        (rs1_idx_o),
    .rs2_idx_o        (rs2_idx_o),
    .id_ex_o          (id_ex_o),
    .stall_o          (stall_o),
    .ras_push_valid_o (ras_push_valid_o),
    .ras_push_data_o  (ras_push_data_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic decode_t decode_word(input logic [31:0] w);
    decode_t r;
    logic [2:0] f3;
    logic [6:0] f7;
    logic ok, u1, u2, ud;
    r = '0;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b1;
    u1 = 1'b0;
    u2 = 1'b0;
    ud = 1'b0;
    case (w[6:0])
      7'h37, 7'h17: begin
        r.exc_op = (w[5]) ? exc_lui : exc_auipc;
        r.alu_op = alu_add;
        r.imm_fmt = fmt_u;
        ud = 1'b1;
      end
      7'h6f: begin
        r.exc_op = exc_jal;
        r.alu_op = alu_add;
        r.imm_fmt = fmt_j;
        ud = 1'b1;
      end
      7'h67: begin
        r.exc_op = exc_jalr;
        r.alu_op = alu_add;
        r.imm_fmt = fmt_i;
        u1 = 1'b1;
        ud = 1'b1;
        ok = (f3 == 3'd0);
      end
      7'h63: begin
        r.exc_op = exc_branch;
        r.imm_fmt = fmt_b;
        u1 = 1'b1;
        u2 = 1'b1;
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        r.alu_op = (f3 == 0) ? alu_beq : (f3 == 1) ? alu_bne : (f3 == 4) ? alu_blt :
                   (f3 == 5) ? alu_bge : (f3 == 6) ? alu_bltu : alu_bgeu;
      end
      7'h03: begin
        r.exc_op = exc_load;
        r.alu_op = alu_add;
        r.imm_fmt = fmt_i;
        u1 = 1'b1;
        ud = 1'b1;
        ok = (f3 != 3) && (f3 < 6);
        r.mem_op = (f3 == 0) ? mem_lb : (f3 == 1) ? mem_lh : (f3 == 2) ? mem_lw :
                   (f3 == 4) ? mem_lbu : mem_lhu;
      end
      7'h23: begin
        r.exc_op = exc_store;
        r.alu_op = alu_add;
        r.imm_fmt = fmt_s;
        u1 = 1'b1;
        u2 = 1'b1;
        ok = (f3 < 3);
        r.mem_op = (f3 == 0) ? mem_sb : (f3 == 1) ? mem_sh : mem_sw;
      end
      7'h13, 7'h33: begin
        u1 = 1'b1;
        ud = 1'b1;
        u2 = w[5];
        r.exc_op = w[5] ? exc_op : exc_opimm;
        r.imm_fmt = w[5] ? fmt_none : fmt_i;
        if (w[5]) ok = (f7 == 0) || (f7 == 7'h20 && (f3 == 0 || f3 == 5));
        else if (f3 == 1) ok = (f7 == 0);
        else if (f3 == 5) ok = (f7 == 0) || (f7 == 7'h20);
        case (f3)
          0: r.alu_op = (w[5] && f7[5]) ? alu_sub : alu_add;
          1: r.alu_op = alu_sll;
          2: r.alu_op = alu_slt;
          3: r.alu_op = alu_sltu;
          4: r.alu_op = alu_xor;
          5: r.alu_op = f7[5] ? alu_sra : alu_srl;
          6: r.alu_op = alu_or;
          default: r.alu_op = alu_and;
        endcase
      end
      7'h73: begin
        r.exc_op = exc_system;
        r.imm_fmt = fmt_i;
        u1 = 1'b1;
        ud = 1'b1;
        ok = (w == `ECALL_ENC) || (w == `EBREAK_ENC) || (w == `MRET_ENC);
      end
      default: ok = 1'b0;
    endcase
    if (!ok) r = '0;
    r.rs1_idx = (ok && u1) ? w[19:15] : 5'd0;
    r.rs2_idx = (ok && u2) ? w[24:20] : 5'd0;
    r.rd_idx = (ok && ud) ? w[11:7] : 5'd0;
    r.trap = {w == `MRET_ENC, w == `EBREAK_ENC, w == `ECALL_ENC, !ok};
    r.is_call = ok && (w[6:0] == 7'h6f || w[6:0] == 7'h67) && (w[11:7] != 0);
    return r;
  endfunction

  function automatic logic [31:0] select_operand(input logic [4:0] idx, input logic [31:0] rfv,
      input logic [4:0] ex_idx, input logic [31:0] exd, input mem_bypass_t m);
    if (idx == 0) return rfv;
    if (idx == ex_idx) return exd;
    if (idx == m.rd_addr) return m.rd_data;
    return rfv;
  endfunction

  function automatic id_ex_t expect_id_ex(input if_id_t f, input decode_t r,
      input logic [31:0] r1, input logic [31:0] r2, input logic [31:0] exd,
      input mem_bypass_t m, input id_ex_t e);
    id_ex_t x;
    logic [31:0] w;
    w = f.inst;
    x = '0;
    x.pc = f.pc;
    x.rs1_idx = r.rs1_idx;
    x.rs2_idx = r.rs2_idx;
    x.rd_idx = r.rd_idx;
    x.rs1_data = select_operand(r.rs1_idx, r1, e.rd_idx, exd, m);
    x.rs2_data = select_operand(r.rs2_idx, r2, e.rd_idx, exd, m);
    case (r.imm_fmt)
      fmt_i: x.imm = 32'($signed(w[31:20]));
      fmt_s: x.imm = 32'($signed({w[31:25], w[11:7]}));
      fmt_b: x.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      fmt_u: x.imm = {w[31:12], 12'b0};
      fmt_j: x.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      default: x.imm = '0;
    endcase
    x.alu_op = r.alu_op;
    x.exc_op = r.exc_op;
    x.mem_op = r.mem_op;
    x.trap = r.trap;
    return x;
  endfunction

  function automatic logic load_use_hazard(input decode_t r, input id_ex_t e);
    return (e.exc_op == exc_load) && ((r.rs1_idx != 0 && r.rs1_idx == e.rd_idx) ||
                                      (r.rs2_idx != 0 && r.rs2_idx == e.rd_idx));
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $random(seed);
    case ($unsigned($random(seed)) % 10)
      0: w[6:0] = 7'h37;
      1: w[6:0] = 7'h17;
      2: w[6:0] = 7'h6f;
      3: {w[14:12], w[6:0]} = {3'd0, 7'h67};
      4: begin
        w[6:0] = 7'h63;
        if (w[14:13] == 2'b01) w[14] = 1'b1;
      end
      5: begin
        w[6:0] = 7'h03;
        if (w[14:12] == 3 || w[14:13] == 2'b11) w[14:12] = 3'd2;
      end
      6: begin
        w[6:0] = 7'h23;
        if (w[14:12] > 2) w[14:12] = w[14:12] % 3;
      end
      7: begin
        w[6:0] = 7'h13;
        if (w[14:12] == 1) w[31:25] = '0;
        if (w[14:12] == 5) w[31:25] = {1'b0, w[30], 5'b0};
      end
      8: begin
        w[6:0] = 7'h33;
        w[31:25] = (w[14:12] == 0 || w[14:12] == 5) ? {1'b0, w[30], 5'b0} : 7'b0;
      end
      default: w = w[0] ? `ECALL_ENC : (w[1] ? `EBREAK_ENC : `MRET_ENC);
    endcase
    return w;
  endfunction

  task automatic add_inst(input logic [31:0] w, input bit fl);
    prog_inst.push_back(w);
    prog_flush.push_back(fl);
  endtask

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // model of decode, execute and memory stages
  always @(posedge clk) begin
    d = decode_word(if_id.inst);
    hold = load_use_hazard(d, exp_ex);
    new_mem = {exp_ex.rd_idx, ex_rd_data_i};
    if (reset_i || flush_i || hold) begin
      exp_ex = '0;
    end else begin
      exp_ex = expect_id_ex(if_id, d, rs1_data_i, rs2_data_i, ex_rd_data_i, mem_bypass_i, exp_ex);
    end
    n_if = if_id;
    n_flush = 1'b0;
    if (!reset_i && !hold) begin
      if (prog_inst.size() > 0) begin
        n_if = {next_pc, prog_inst.pop_front()};
        n_flush = prog_flush.pop_front();
        next_pc = next_pc + 4;
      end else begin
        n_if.inst = NOP;
        done = 1'b1;
      end
    end
    nd = decode_word(n_if.inst);
    if_id <= n_if;
    flush_i <= n_flush;
    ex_rd_data_i <= $random(seed);
    mem_bypass_i <= new_mem;
    rs1_data_i <= rf[nd.rs1_idx];
    rs2_data_i <= rf[nd.rs2_idx];
    exp_rs1_idx = nd.rs1_idx;
    exp_rs2_idx = nd.rs2_idx;
    exp_stall = load_use_hazard(nd, exp_ex);
    exp_push = nd.is_call && !n_flush;
    exp_push_data = n_if.pc + 32'd4;
  end

  always @(negedge clk) begin
    check_field("pc", id_ex_o.pc, exp_ex.pc);
    check_field("rs1_idx", id_ex_o.rs1_idx, exp_ex.rs1_idx);
    check_field("rs2_idx", id_ex_o.rs2_idx, exp_ex.rs2_idx);
    check_field("rd_idx", id_ex_o.rd_idx, exp_ex.rd_idx);
    check_field("rs1_data", id_ex_o.rs1_data, exp_ex.rs1_data);
    check_field("rs2_data", id_ex_o.rs2_data, exp_ex.rs2_data);
    check_field("imm", id_ex_o.imm, exp_ex.imm);
    check_field("alu_op", id_ex_o.alu_op, exp_ex.alu_op);
    check_field("exc_op", id_ex_o.exc_op, exp_ex.exc_op);
    check_field("mem_op", id_ex_o.mem_op, exp_ex.mem_op);
    check_field("trap", id_ex_o.trap, exp_ex.trap);
    check_field("rs1_idx_o", rs1_idx_o, exp_rs1_idx);
    check_field("rs2_idx_o", rs2_idx_o, exp_rs2_idx);
    check_field("stall_o", stall_o, exp_stall);
    check_field("ras_push_valid_o", ras_push_valid_o, exp_push);
    if (exp_push) check_field("ras_push_data_o", ras_push_data_o, exp_push_data);
  end

  always @(dut.u_props.fails) begin
    if (dut.u_props.fails != 0) begin
      $display("a concurrent property on id_stage did not hold");
      $display("tests failed");
      $fatal(1);
    end
  end

  initial begin
    #(CYCLE_LIMIT * 10);
    $display("timeout: the stimulus did not finish within %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $fatal(1);
  end

  initial begin
    reset_i = 1'b1;
    if_id = {32'h0, NOP};
    flush_i = 1'b0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_data_i = '0;
    mem_bypass_i = '0;
    foreach (rf[i]) rf[i] = (i == 0) ? 32'h0 : $random(seed);
    // forwarding priority and x0
    add_inst(i_type(12'h123, 0, 0, 5, 7'h13), 0);
    add_inst(i_type(12'h456, 0, 0, 6, 7'h13), 0);
    add_inst(r_type(0, 6, 5, 0, 7, 7'h33), 0);
    add_inst(i_type(12'h111, 0, 0, 5, 7'h13), 0);
    add_inst(i_type(12'h222, 0, 0, 5, 7'h13), 0);
    add_inst(r_type(0, 0, 5, 0, 8, 7'h33), 0);
    // load then dependent use
    add_inst(i_type(12'h004, 1, 3'b010, 9, 7'h03), 0);
    add_inst(r_type(0, 2, 9, 0, 10, 7'h33), 0);
    // calls, with and without flush
    add_inst(32'h0080_00ef, 1);
    add_inst(32'h0080_00ef, 0);
    add_inst(i_type(12'h010, 5, 0, 1, 7'h67), 0);
    add_inst(32'h0080_006f, 0);
    // traps
    add_inst(`ECALL_ENC, 0);
    add_inst(`EBREAK_ENC, 0);
    add_inst(`MRET_ENC, 0);
    add_inst(32'h3052_9073, 0);
    add_inst(r_type(7'h01, 2, 1, 0, 3, 7'h33), 0);
    foreach (undef_ops[i]) add_inst({$random(seed)} & 32'hffff_ff80 | undef_ops[i], 0);
    repeat (N_RANDOM) add_inst(random_word(), ($random(seed) & 15) == 0);
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;
    wait (done);
    repeat (3) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
id_pkg.sv
inst_decoder.sv
imm_gen.sv
operand_forward.sv
id_ex_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - include_dirs:
      - .
    files:
      - id_pkg.sv
      - inst_decoder.sv
      - imm_gen.sv
      - operand_forward.sv
      - id_ex_reg.sv
      - id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - id_stage_props.sv
      - tb_id_stage.sv
